// File: Bender.yml
package:
  name: k005293

sources:
  - hw/video_fmt_pkg.sv
  - hw/prio_pkg.sv
  - hw/prio_timing_ctrl.sv
  - hw/tile_attr_pipe.sv
  - hw/obj_pixel_latch.sv
  - hw/priority_decoder.sv
  - hw/layer_mixer.sv
  - hw/k005293_top.sv
  - target: simulation
    files:
      - sim/k005293_tb.sv

// File: hw/k005293_top.sv
module k005293_top
(
    input  logic                        i_EMU_MCLK,
    input  logic                        i_rst_n,
    input  logic                        i_emu_clk6mpcen_n,
    input  logic                        i_hflip,
    input  logic                        i_shifta1,
    input  logic                        i_shifta2,
    input  logic                        i_shiftb,
    input  logic                        i_abs_n1h,
    input  logic                        i_abs_n6n7h,
    input  logic                        i_abs_n2n3h,
    input  video_fmt_pkg::pixel_t       i_a_pixel,
    input  video_fmt_pkg::pixel_t       i_b_pixel,
    input  video_fmt_pkg::obj_word_t    i_objbuf_data,
    input  logic                        i_a_trn_n,
    input  logic                        i_b_trn_n,
    input  logic                        i_vhff,
    input  video_fmt_pkg::palette_t     i_vc,
    input  prio_pkg::pr_a_t             i_pr,
    output logic                        o_a_flip,
    output logic                        o_b_flip,
    output video_fmt_pkg::color_code_t  o_cd
);

logic [3:0]                 a_stage_en;
logic [2:0]                 b_stage_en;
logic                       obj_latch_en;
logic                       pix_en;
logic                       obj_sel_hi;
prio_pkg::pr_a_t            a_pr;
prio_pkg::pr_b_t            b_pr;
video_fmt_pkg::palette_t    a_palette;
video_fmt_pkg::palette_t    b_palette;
video_fmt_pkg::obj_pixel_t  obj_pixel;
prio_pkg::prio_mode_e       mode;

prio_timing_ctrl u_timing (
    .i_EMU_MCLK        (i_EMU_MCLK),
    .i_rst_n           (i_rst_n),
    .i_emu_clk6mpcen_n (i_emu_clk6mpcen_n),
    .i_abs_n1h         (i_abs_n1h),
    .i_abs_n2n3h       (i_abs_n2n3h),
    .i_abs_n6n7h       (i_abs_n6n7h),
    .i_shifta1         (i_shifta1),
    .i_shifta2         (i_shifta2),
    .i_shiftb          (i_shiftb),
    .i_hflip           (i_hflip),
    .o_a_stage_en      (a_stage_en),
    .o_b_stage_en      (b_stage_en),
    .o_obj_latch_en    (obj_latch_en),
    .o_pix_en          (pix_en),
    .o_obj_sel_hi      (obj_sel_hi)
);

// Flip of A leaves one stage before its priority
tile_attr_pipe #(.STAGES(4), .PR_W(prio_pkg::PR_A_W), .FLIP_TAP(3)) u_attr_a (
    .i_EMU_MCLK (i_EMU_MCLK),
    .i_rst_n    (i_rst_n),
    .i_stage_en (a_stage_en),
    .i_pr       (i_pr),
    .i_vhff     (i_vhff),
    .i_vc       (i_vc),
    .o_pr       (a_pr),
    .o_palette  (a_palette),
    .o_flip     (o_a_flip)
);

tile_attr_pipe #(.STAGES(3), .PR_W(prio_pkg::PR_B_W), .FLIP_TAP(3)) u_attr_b (
    .i_EMU_MCLK (i_EMU_MCLK),
    .i_rst_n    (i_rst_n),
    .i_stage_en (b_stage_en),
    .i_pr       (i_pr[prio_pkg::PR_B_W-1:0]),   // Low bits only
    .i_vhff     (i_vhff),
    .i_vc       (i_vc),
    .o_pr       (b_pr),
    .o_palette  (b_palette),
    .o_flip     (o_b_flip)
);

obj_pixel_latch u_obj (
    .i_EMU_MCLK    (i_EMU_MCLK),
    .i_rst_n       (i_rst_n),
    .i_latch_en    (obj_latch_en),
    .i_sel_hi      (obj_sel_hi),
    .i_objbuf_data (i_objbuf_data),
    .o_obj_pixel   (obj_pixel)
);

priority_decoder u_dec (
    .i_a_pr (a_pr),
    .i_b_pr (b_pr),
    .o_mode (mode)
);

layer_mixer u_mix (
    .i_EMU_MCLK  (i_EMU_MCLK),
    .i_rst_n     (i_rst_n),
    .i_pix_en    (pix_en),
    .i_mode      (mode),
    .i_a_trn_n   (i_a_trn_n),
    .i_b_trn_n   (i_b_trn_n),
    .i_a_pixel   (i_a_pixel),
    .i_b_pixel   (i_b_pixel),
    .i_a_palette (a_palette),
    .i_b_palette (b_palette),
    .i_obj_pixel (obj_pixel),
    .o_cd        (o_cd)
);

endmodule

// File: hw/layer_mixer.sv
module layer_mixer
(
    input  logic                        i_EMU_MCLK,
    input  logic                        i_rst_n,
    input  logic                        i_pix_en,
    input  prio_pkg::prio_mode_e        i_mode,
    input  logic                        i_a_trn_n,
    input  logic                        i_b_trn_n,
    input  video_fmt_pkg::pixel_t       i_a_pixel,
    input  video_fmt_pkg::pixel_t       i_b_pixel,
    input  video_fmt_pkg::palette_t     i_a_palette,
    input  video_fmt_pkg::palette_t     i_b_palette,
    input  video_fmt_pkg::obj_pixel_t   i_obj_pixel,
    output video_fmt_pkg::color_code_t  o_cd
);

localparam int OBJ_PAD_W = video_fmt_pkg::CODE_W - video_fmt_pkg::OBJ_PIXEL_W;

localparam prio_pkg::layer_e la = prio_pkg::layer_tma;
localparam prio_pkg::layer_e lb = prio_pkg::layer_tmb;
localparam prio_pkg::layer_e lo = prio_pkg::layer_obj;

logic             obj_trn_n;
logic [2:0]       trn;
prio_pkg::layer_e row [7:0];
prio_pkg::layer_e layer;

assign obj_trn_n = |i_obj_pixel[3:0];                    // Zero nibble is see-through
assign trn       = ~{i_a_trn_n, i_b_trn_n, obj_trn_n};   // A, B, sprite; set when clear

//////////////////////////////
// Layer table per mode
//////////////////////////////

// Entries run from trn 7 down to trn 0
always_comb
begin
    case (i_mode)
        prio_pkg::mode_a_over_b:                    row = '{la, la, lb, lb, la, la, la, la};
        prio_pkg::mode_a_over_b_over_obj:           row = '{la, lo, lb, lb, la, la, la, la};
        prio_pkg::mode_a_over_b_masked_obj:         row = '{la, la, lo, lo, la, la, la, la};
        prio_pkg::mode_a_over_obj_1:                row = '{la, lo, la, lo, la, la, la, la};
        prio_pkg::mode_a_over_obj_2:                row = '{la, lo, lo, lo, la, la, la, la};
        prio_pkg::mode_a_over_obj_over_b:           row = '{la, lo, lb, lo, la, la, la, la};
        prio_pkg::mode_b:                           row = '{default: lb};
        prio_pkg::mode_b_over_a:                    row = '{lb, lb, lb, lb, la, la, lb, lb};
        prio_pkg::mode_b_over_a_over_obj:           row = '{lo, lo, lb, lb, la, la, lb, lb};
        prio_pkg::mode_b_over_obj:                  row = '{lo, lo, lb, lb, lo, lo, lb, lb};
        prio_pkg::mode_b_over_obj_over_a:           row = '{lo, lo, lb, lb, la, lo, lb, lb};
        prio_pkg::mode_obj:                         row = '{default: lo};
        prio_pkg::mode_obj_over_a:                  row = '{lo, lo, lo, lo, la, lo, la, lo};
        prio_pkg::mode_obj_over_a_over_b:           row = '{lo, lo, lb, lo, la, lo, la, lo};
        prio_pkg::mode_obj_over_b:                  row = '{lo, lo, lb, lo, lo, lo, lb, lo};
        prio_pkg::mode_obj_over_b_over_a:           row = '{lo, lo, lb, lo, la, lo, lb, lo};
        prio_pkg::mode_a_over_b_masked_obj_over_b:  row = '{la, la, lb, lo, la, la, la, la};
        prio_pkg::mode_a_punched_b_over_obj:        row = '{lo, lo, lb, lb, lo, lo, lo, lo};
        prio_pkg::mode_a_punched_b_over_obj_over_a: row = '{lo, lo, lb, lb, la, lo, la, lo};
        prio_pkg::mode_b_over_a_masked_obj:         row = '{lb, lb, lb, lb, lo, lo, lb, lb};
        prio_pkg::mode_b_over_a_masked_obj_over_a:  row = '{lb, lb, lb, lb, la, lo, lb, lb};
        prio_pkg::mode_b_punched_a_over_obj:        row = '{lo, lo, lo, lo, la, la, lo, lo};
        prio_pkg::mode_b_punched_a_over_obj_over_b: row = '{lo, lo, lb, lo, la, la, lb, lo};
        prio_pkg::mode_obj_over_a_punched_b:        row = '{lo, lo, lb, lo, lo, lo, lo, lo};
        prio_pkg::mode_obj_over_b_punched_a:        row = '{lo, lo, lo, lo, la, lo, lo, lo};
        default:                                    row = '{default: la};   // A only
    endcase
end

assign layer = row[trn];

//////////////////////////////
// Palette code register
//////////////////////////////

always_ff @(posedge i_EMU_MCLK or negedge i_rst_n)
begin
    if (!i_rst_n)
    begin
        o_cd <= '0;
    end
    else if (i_pix_en)
    begin
        case (layer)
            prio_pkg::layer_tma: o_cd <= {i_a_palette, i_a_pixel};
            prio_pkg::layer_tmb: o_cd <= {i_b_palette, i_b_pixel};
            default:             o_cd <= {{OBJ_PAD_W{1'b0}}, i_obj_pixel};   // Sprite bank
        endcase
    end
end

a_layer_legal: assert property (@(posedge i_EMU_MCLK) disable iff (!i_rst_n)
    layer inside {prio_pkg::layer_tma, prio_pkg::layer_tmb, prio_pkg::layer_obj});

endmodule

// File: hw/obj_pixel_latch.sv
module obj_pixel_latch
(
    input  logic                        i_EMU_MCLK,
    input  logic                        i_rst_n,
    input  logic                        i_latch_en,
    input  logic                        i_sel_hi,
    input  video_fmt_pkg::obj_word_t    i_objbuf_data,
    output video_fmt_pkg::obj_pixel_t   o_obj_pixel
);

localparam int PX_W = video_fmt_pkg::OBJ_PIXEL_W;

video_fmt_pkg::obj_pixel_t px_odd_q;
video_fmt_pkg::obj_pixel_t px_even_q;

always_ff @(posedge i_EMU_MCLK or negedge i_rst_n)
begin
    if (!i_rst_n)
    begin
        px_odd_q  <= '0;
        px_even_q <= '0;
    end
    else if (i_latch_en)
    begin
        px_odd_q  <= i_objbuf_data[2*PX_W-1:PX_W];     // Buffer A half
        px_even_q <= i_objbuf_data[PX_W-1:0];          // Buffer B half
    end
end

// Flip swaps which half is shown first
assign o_obj_pixel = i_sel_hi ? px_odd_q : px_even_q;

endmodule

// File: hw/prio_pkg.sv
package prio_pkg;

//////////////////////////////
// Priority fields
//////////////////////////////

localparam int PR_A_W = 4;          // All four bits of A are decoded
localparam int PR_B_W = 2;          // Upper two bits of B have no effect

typedef logic [PR_A_W-1:0] pr_a_t;
typedef logic [PR_B_W-1:0] pr_b_t;

//////////////////////////////
// Priority modes
//////////////////////////////

// Names list the layer stack from front to back
typedef enum logic [4:0] {
    mode_a,
    mode_a_over_b,
    mode_a_over_b_over_obj,
    mode_a_over_b_masked_obj,
    mode_a_over_obj_1,
    mode_a_over_obj_2,
    mode_a_over_obj_over_b,
    mode_b,
    mode_b_over_a,
    mode_b_over_a_over_obj,
    mode_b_over_obj,
    mode_b_over_obj_over_a,
    mode_obj,
    mode_obj_over_a,
    mode_obj_over_a_over_b,
    mode_obj_over_b,
    mode_obj_over_b_over_a,
    mode_a_over_b_masked_obj_over_b,
    mode_a_punched_b_over_obj,
    mode_a_punched_b_over_obj_over_a,
    mode_b_over_a_masked_obj,
    mode_b_over_a_masked_obj_over_a,
    mode_b_punched_a_over_obj,
    mode_b_punched_a_over_obj_over_b,
    mode_obj_over_a_punched_b,
    mode_obj_over_b_punched_a
} prio_mode_e;

typedef enum logic [1:0] {
    layer_tma = 2'b00,
    layer_tmb = 2'b01,
    layer_obj = 2'b10
} layer_e;

endpackage

// File: hw/prio_timing_ctrl.sv
module prio_timing_ctrl
(
    input  logic       i_EMU_MCLK,
    input  logic       i_rst_n,
    input  logic       i_emu_clk6mpcen_n,
    input  logic       i_abs_n1h,
    input  logic       i_abs_n2n3h,
    input  logic       i_abs_n6n7h,
    input  logic       i_shifta1,
    input  logic       i_shifta2,
    input  logic       i_shiftb,
    input  logic       i_hflip,
    output logic [3:0] o_a_stage_en,
    output logic [2:0] o_b_stage_en,
    output logic       o_obj_latch_en,
    output logic       o_pix_en,
    output logic       o_obj_sel_hi
);

//////////////////////////////
// Position decode
//////////////////////////////

logic pix_ce;
logic at_px3;
logic at_px7;
logic at_odd;

assign pix_ce = ~i_emu_clk6mpcen_n;                 // 6 MHz pixel slot
assign at_px3 = ~(i_abs_n2n3h | i_abs_n1h);         // Pixel 3 of the tile
assign at_px7 = ~(i_abs_n6n7h | i_abs_n1h);         // Pixel 7 of the tile
assign at_odd = ~i_abs_n1h;                         // Every odd pixel

//////////////////////////////
// Stage load enables
//////////////////////////////

// Tilemap A chain: px3, px7, SHIFT-A1, SHIFT-A2
assign o_a_stage_en[0] = pix_ce & at_px3;
assign o_a_stage_en[1] = pix_ce & at_px7;
assign o_a_stage_en[2] = pix_ce & ~i_shifta1;
assign o_a_stage_en[3] = pix_ce & ~i_shifta2;

// Tilemap B starts half a tile later
assign o_b_stage_en[0] = pix_ce & at_px7;
assign o_b_stage_en[1] = pix_ce & at_px3;
assign o_b_stage_en[2] = pix_ce & ~i_shiftb;

assign o_obj_latch_en = pix_ce & at_odd;            // Both sprite bytes at once
assign o_pix_en       = pix_ce;                     // Output code register

// Odd byte when 1H and flip disagree
assign o_obj_sel_hi = at_odd ^ i_hflip;

a_enables_known: assert property (@(posedge i_EMU_MCLK) disable iff (!i_rst_n)
    !$isunknown({o_a_stage_en, o_b_stage_en, o_obj_latch_en, o_pix_en}));

endmodule

// File: hw/priority_decoder.sv
module priority_decoder
(
    input  prio_pkg::pr_a_t         i_a_pr,
    input  prio_pkg::pr_b_t         i_b_pr,
    output prio_pkg::prio_mode_e    o_mode
);

//////////////////////////////
// Priority field decode
//////////////////////////////

// First match wins, B field in the upper two bits
always_comb
begin
    casez ({i_b_pr, i_a_pr})
        6'b??_0101: o_mode = prio_pkg::mode_a;
        6'b?1_1101: o_mode = prio_pkg::mode_a_over_b;
        6'b?1_1111: o_mode = prio_pkg::mode_a_over_b_over_obj;
        6'b00_1101: o_mode = prio_pkg::mode_a_over_b_masked_obj;
        6'b??_0111: o_mode = prio_pkg::mode_a_over_obj_1;
        6'b00_1111: o_mode = prio_pkg::mode_a_over_obj_2;
        6'b10_1111: o_mode = prio_pkg::mode_a_over_obj_over_b;
        6'b01_00??: o_mode = prio_pkg::mode_b;
        6'b01_10?1: o_mode = prio_pkg::mode_b_over_a;
        6'b11_10?1: o_mode = prio_pkg::mode_b_over_a_over_obj;
        6'b11_00??: o_mode = prio_pkg::mode_b_over_obj;
        6'b11_1000: o_mode = prio_pkg::mode_b_over_obj;             // Second code, same mode
        6'b11_1010: o_mode = prio_pkg::mode_b_over_obj_over_a;
        6'b00_00??: o_mode = prio_pkg::mode_obj;
        6'b00_1?00: o_mode = prio_pkg::mode_obj;
        6'b??_0100: o_mode = prio_pkg::mode_obj;                    // Any B field
        6'b??_0110: o_mode = prio_pkg::mode_obj_over_a;
        6'b00_1110: o_mode = prio_pkg::mode_obj_over_a;
        6'b10_1110: o_mode = prio_pkg::mode_obj_over_a_over_b;
        6'b10_00??: o_mode = prio_pkg::mode_obj_over_b;
        6'b10_1000: o_mode = prio_pkg::mode_obj_over_b;
        6'b10_1010: o_mode = prio_pkg::mode_obj_over_b_over_a;
        6'b10_1101: o_mode = prio_pkg::mode_a_over_b_masked_obj_over_b;
        6'b?1_1100: o_mode = prio_pkg::mode_a_punched_b_over_obj;
        6'b?1_1110: o_mode = prio_pkg::mode_a_punched_b_over_obj_over_a;
        6'b01_1000: o_mode = prio_pkg::mode_b_over_a_masked_obj;
        6'b01_1010: o_mode = prio_pkg::mode_b_over_a_masked_obj_over_a;
        6'b00_10?1: o_mode = prio_pkg::mode_b_punched_a_over_obj;
        6'b10_10?1: o_mode = prio_pkg::mode_b_punched_a_over_obj_over_b;
        6'b10_1100: o_mode = prio_pkg::mode_obj_over_a_punched_b;
        6'b00_1010: o_mode = prio_pkg::mode_obj_over_b_punched_a;
        default:    o_mode = prio_pkg::mode_a;                      // Fallback is A only
    endcase
end

endmodule

// File: hw/tile_attr_pipe.sv
module tile_attr_pipe
#(
    parameter int STAGES   = 4,
    parameter int PR_W     = 4,
    parameter int FLIP_TAP = 3
)
(
    input  logic                        i_EMU_MCLK,
    input  logic                        i_rst_n,
    input  logic [STAGES-1:0]           i_stage_en,
    input  logic [PR_W-1:0]             i_pr,
    input  logic                        i_vhff,
    input  video_fmt_pkg::palette_t     i_vc,
    output logic [PR_W-1:0]             o_pr,
    output video_fmt_pkg::palette_t     o_palette,
    output logic                        o_flip
);

localparam int WORD_W = PR_W + 1 + video_fmt_pkg::PALETTE_W;
localparam int FLIP_BIT = video_fmt_pkg::PALETTE_W;

//////////////////////////////
// Property delay chain
//////////////////////////////

// Word layout is priority, flip, palette from MSB down
logic [WORD_W-1:0] stage_q [STAGES];

always_ff @(posedge i_EMU_MCLK or negedge i_rst_n)
begin
    if (!i_rst_n)
    begin
        for (int s = 0; s < STAGES; s++)
        begin
            stage_q[s] <= '0;
        end
    end
    else
    begin
        if (i_stage_en[0])
        begin
            stage_q[0] <= {i_pr, i_vhff, i_vc};         // Fresh tile properties
        end
        for (int s = 1; s < STAGES; s++)
        begin
            if (i_stage_en[s])
            begin
                stage_q[s] <= stage_q[s-1];             // Shift one slot on
            end
        end
    end
end

assign o_pr      = stage_q[STAGES-1][WORD_W-1 -: PR_W];
assign o_palette = stage_q[STAGES-1][video_fmt_pkg::PALETTE_W-1:0];
assign o_flip    = stage_q[FLIP_TAP-1][FLIP_BIT];       // Tap may sit early

a_flip_tap_range: assert property (@(posedge i_EMU_MCLK)
    (FLIP_TAP >= 1) && (FLIP_TAP <= STAGES));

endmodule

// File: hw/video_fmt_pkg.sv
package video_fmt_pkg;

//////////////////////////////
// Pixel and palette widths
//////////////////////////////

localparam int PIXEL_W     = 4;     // Tilemap pixel index
localparam int PALETTE_W   = 7;     // Tile palette select
localparam int OBJ_PIXEL_W = 8;     // Sprite buffer pixel
localparam int CODE_W      = 11;    // Palette code to the color RAM

//////////////////////////////
// Vector types
//////////////////////////////

typedef logic [PIXEL_W-1:0]       pixel_t;
typedef logic [PALETTE_W-1:0]     palette_t;

// Low nibble of zero marks a transparent sprite pixel
typedef logic [OBJ_PIXEL_W-1:0]   obj_pixel_t;

// Odd pixel in the high byte, even pixel in the low byte
typedef logic [2*OBJ_PIXEL_W-1:0] obj_word_t;

typedef logic [CODE_W-1:0]        color_code_t;

endpackage

// File: sim/k005293_tb.sv
module k005293_tb;

localparam int NUM_ROWS        = 24;
localparam int HOLD_CYCLES     = 8;      // Output settles after 5 cycles
localparam int CLK_PERIOD      = 10;
localparam int RESET_CYCLES    = 2;
localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_ROWS * HOLD_CYCLES + 40;

localparam int WIN_A   = 0;
localparam int WIN_B   = 1;
localparam int WIN_OBJ = 2;

logic                       emu_mclk;
logic                       rst_n;
logic                       clk6mpcen_n;
logic                       hflip;
logic                       shifta1;
logic                       shifta2;
logic                       shiftb;
logic                       abs_n1h;
logic                       abs_n6n7h;
logic                       abs_n2n3h;
video_fmt_pkg::pixel_t      a_pixel;
video_fmt_pkg::pixel_t      b_pixel;
video_fmt_pkg::obj_word_t   objbuf_data;
logic                       a_trn_n;
logic                       b_trn_n;
logic                       vhff;
video_fmt_pkg::palette_t    vc;
prio_pkg::pr_a_t            pr;
logic                       a_flip;
logic                       b_flip;
video_fmt_pkg::color_code_t cd;

//////////////////////////////
// Stimulus table
//////////////////////////////

prio_pkg::pr_a_t            tbl_pr      [NUM_ROWS];
logic                       tbl_vhff    [NUM_ROWS];
video_fmt_pkg::palette_t    tbl_vc      [NUM_ROWS];
video_fmt_pkg::pixel_t      tbl_a_pix   [NUM_ROWS];
video_fmt_pkg::pixel_t      tbl_b_pix   [NUM_ROWS];
logic                       tbl_a_trn_n [NUM_ROWS];
logic                       tbl_b_trn_n [NUM_ROWS];
logic                       tbl_hflip   [NUM_ROWS];
video_fmt_pkg::obj_word_t   tbl_obj     [NUM_ROWS];
video_fmt_pkg::color_code_t tbl_exp_cd  [NUM_ROWS];

int          n_rows;
int          errors;
logic [31:0] lfsr_state;

k005293_top k005293_top_i (
    .i_EMU_MCLK        (emu_mclk),
    .i_rst_n           (rst_n),
    .i_emu_clk6mpcen_n (clk6mpcen_n),
    .i_hflip           (hflip),
    .i_shifta1         (shifta1),
    .i_shifta2         (shifta2),
    .i_shiftb          (shiftb),
    .i_abs_n1h         (abs_n1h),
    .i_abs_n6n7h       (abs_n6n7h),
    .i_abs_n2n3h       (abs_n2n3h),
    .i_a_pixel         (a_pixel),
    .i_b_pixel         (b_pixel),
    .i_objbuf_data     (objbuf_data),
    .i_a_trn_n         (a_trn_n),
    .i_b_trn_n         (b_trn_n),
    .i_vhff            (vhff),
    .i_vc              (vc),
    .i_pr              (pr),
    .o_a_flip          (a_flip),
    .o_b_flip          (b_flip),
    .o_cd              (cd)
);

initial
begin
    emu_mclk = 1'b0;
    forever #(CLK_PERIOD / 2) emu_mclk = ~emu_mclk;
end

// Galois form, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
    begin
        return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
endfunction

function automatic logic [15:0] take_bits(input int n);
    logic [15:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
        bits       = {bits[14:0], lfsr_state[0]};    // One step per bit
        lfsr_state = lfsr_next(lfsr_state);
    end
    return bits;
endfunction

// Zero low nibble makes the sprite pixel see-through
function automatic video_fmt_pkg::obj_pixel_t obj_byte(input logic see_through);
    logic [15:0] bits;
    logic [7:0]  px;
    bits     = take_bits(4);
    px[7:4]  = bits[3:0];
    bits     = take_bits(3);
    px[3:0]  = see_through ? 4'h0 : {bits[2:0], 1'b1};
    return px;
endfunction

task automatic add_row(input logic [3:0] pr_v, input logic a_clear, input logic b_clear,
                       input logic obj_clear, input logic hflip_v, input int winner);
    video_fmt_pkg::obj_pixel_t hi_byte;
    video_fmt_pkg::obj_pixel_t lo_byte;
    video_fmt_pkg::obj_pixel_t shown;
    logic [15:0]               bits;
    hi_byte = obj_byte(obj_clear);
    lo_byte = obj_byte(obj_clear);
    shown   = hflip_v ? lo_byte : hi_byte;          // 1H held low
    tbl_pr[n_rows]      = pr_v;
    bits                = take_bits(1);
    tbl_vhff[n_rows]    = bits[0];
    bits                = take_bits(7);
    tbl_vc[n_rows]      = bits[6:0];
    bits                = take_bits(4);
    tbl_a_pix[n_rows]   = bits[3:0];
    bits                = take_bits(4);
    tbl_b_pix[n_rows]   = bits[3:0];
    tbl_a_trn_n[n_rows] = ~a_clear;
    tbl_b_trn_n[n_rows] = ~b_clear;
    tbl_hflip[n_rows]   = hflip_v;
    tbl_obj[n_rows]     = {hi_byte, lo_byte};
    case (winner)
        WIN_A:   tbl_exp_cd[n_rows] = {tbl_vc[n_rows], tbl_a_pix[n_rows]};
        WIN_B:   tbl_exp_cd[n_rows] = {tbl_vc[n_rows], tbl_b_pix[n_rows]};
        default: tbl_exp_cd[n_rows] = {3'b000, shown};
    endcase
    n_rows++;
endtask

task automatic build_table();
    int winner;
    for (int t = 0; t < 8; t++)
    begin
        add_row(4'b0101, t[2], t[1], t[0], 1'b0, WIN_A);    // A wins whatever is clear
    end
    for (int t = 0; t < 4; t++)
    begin
        add_row(4'b0001, t[1], t[0], t[1], 1'b0, WIN_B);
    end
    add_row(4'b0000, 1'b0, 1'b0, 1'b0, 1'b0, WIN_OBJ);     // Odd byte shown
    add_row(4'b0000, 1'b1, 1'b1, 1'b0, 1'b1, WIN_OBJ);     // Even byte shown
    add_row(4'b0000, 1'b0, 1'b1, 1'b1, 1'b0, WIN_OBJ);
    add_row(4'b0000, 1'b1, 1'b0, 1'b0, 1'b1, WIN_OBJ);
    // A over B falls back to A when both tilemaps are clear
    for (int t = 0; t < 8; t++)
    begin
        winner = !t[2] ? WIN_A : (!t[1] ? WIN_B : WIN_A);
        add_row(4'b1101, t[2], t[1], t[0], t[0], winner);
    end
endtask

//////////////////////////////
// Main sequence
//////////////////////////////

initial
begin
    errors      = 0;
    n_rows      = 0;
    lfsr_state  = 32'h2f28;
    rst_n       = 1'b0;
    clk6mpcen_n = 1'b0;                             // Every MCLK is a pixel slot
    abs_n1h     = 1'b0;
    abs_n2n3h   = 1'b0;
    abs_n6n7h   = 1'b0;
    shifta1     = 1'b0;
    shifta2     = 1'b0;
    shiftb      = 1'b0;
    hflip       = 1'b0;
    a_pixel     = '0;
    b_pixel     = '0;
    objbuf_data = '0;
    a_trn_n     = 1'b1;
    b_trn_n     = 1'b1;
    vhff        = 1'b0;
    vc          = '0;
    pr          = '0;
    build_table();

    repeat (RESET_CYCLES) @(negedge emu_mclk);
    if (cd !== '0)
    begin
        errors++;
        $display("Fail at %0t: o_cd expected %h got %h", $time, 11'h000, cd);
    end
    if (a_flip !== 1'b0)
    begin
        errors++;
        $display("Fail at %0t: o_a_flip expected %b got %b", $time, 1'b0, a_flip);
    end
    if (b_flip !== 1'b0)
    begin
        errors++;
        $display("Fail at %0t: o_b_flip expected %b got %b", $time, 1'b0, b_flip);
    end
    rst_n = 1'b1;

    for (int r = 0; r < NUM_ROWS; r++)
    begin
        pr          = tbl_pr[r];
        vhff        = tbl_vhff[r];
        vc          = tbl_vc[r];
        a_pixel     = tbl_a_pix[r];
        b_pixel     = tbl_b_pix[r];
        a_trn_n     = tbl_a_trn_n[r];
        b_trn_n     = tbl_b_trn_n[r];
        hflip       = tbl_hflip[r];
        objbuf_data = tbl_obj[r];
        repeat (HOLD_CYCLES) @(negedge emu_mclk);
        if (cd !== tbl_exp_cd[r])
        begin
            errors++;
            $display("Fail at %0t: o_cd row %0d expected %h got %h",
                     $time, r, tbl_exp_cd[r], cd);
        end
        if (a_flip !== tbl_vhff[r])
        begin
            errors++;
            $display("Fail at %0t: o_a_flip row %0d expected %b got %b",
                     $time, r, tbl_vhff[r], a_flip);
        end
        if (b_flip !== tbl_vhff[r])
        begin
            errors++;
            $display("Fail at %0t: o_b_flip row %0d expected %b got %b",
                     $time, r, tbl_vhff[r], b_flip);
        end
    end

    $display("Run finished with %0d errors over %0d rows", errors, NUM_ROWS);
    if (errors == 0)
    begin
        $display("all tests passed");
    end
    else
    begin
        $display("tests failed");
    end
    $finish;
end

initial
begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before all table rows were checked");
    $display("tests failed");
    $finish;
end

endmodule

// File: src.f
hw/video_fmt_pkg.sv
hw/prio_pkg.sv
hw/prio_timing_ctrl.sv
hw/tile_attr_pipe.sv
hw/obj_pixel_latch.sv
hw/priority_decoder.sv
hw/layer_mixer.sv
hw/k005293_top.sv
sim/k005293_tb.sv
